//--- div_pkg.sv
package div_pkg;

	// width of every operand, magnitude and result word.
	localparam int div_width = 32;

	// quotient bits retired in one core iteration.
	// the core also works with 1 or 4, as long as it divides div_width.
	localparam int div_bits_per_cycle = 2;

	// iterations needed to retire the whole quotient.
	localparam int div_iterations = div_width / div_bits_per_cycle;

	// one spare bit so the counter can also hold div_iterations itself.
	localparam int div_count_width = $clog2(div_iterations) + 1;

	// edges from the accepting edge to the edge that raises ready.
	// one edge in the sign stage, the core load, then one edge in the result stage.
	localparam int div_latency = div_iterations + 2;

	// unsigned word, used for raw operands, magnitudes and signed results alike.
	typedef logic [div_width-1:0] div_word_t;

endpackage

//--- div_operand_if.sv
`timescale 1ns/1ns

interface div_operand_if;
	import div_pkg::*;

	logic valid;               // one-cycle pulse, the core loads on it.
	div_word_t dividend_mag;
	div_word_t divisor_mag;
	logic sign_q;              // quotient is to be negated.
	logic sign_r;              // remainder is to be negated.
	logic busy;                // core holds a division in flight.

	modport prep (
		output valid,
		output dividend_mag,
		output divisor_mag,
		output sign_q,
		output sign_r,
		input busy
	);

	modport core (
		input valid,
		input dividend_mag,
		input divisor_mag,
		input sign_q,
		input sign_r,
		output busy
	);

endinterface

//--- div_result_if.sv
`timescale 1ns/1ns

interface div_result_if;
	import div_pkg::*;

	logic valid;               // one-cycle pulse, fields are stable with it.
	div_word_t quotient_mag;
	div_word_t remainder_mag;
	logic sign_q;
	logic sign_r;

	modport core (
		output valid,
		output quotient_mag,
		output remainder_mag,
		output sign_q,
		output sign_r
	);

	modport fix (
		input valid,
		input quotient_mag,
		input remainder_mag,
		input sign_q,
		input sign_r
	);

endinterface

//--- div_sign_prep.sv
`timescale 1ns/1ns

module div_sign_prep (
	input logic clk,
	input logic rst,
	input div_pkg::div_word_t dividend,
	input div_pkg::div_word_t divisor,
	input logic start,
	div_operand_if.prep op
);
	import div_pkg::*;

	logic start_q;
	logic start_rise;
	logic accept;
	logic valid_q;
	div_word_t dividend_mag_q;
	div_word_t divisor_mag_q;
	logic sign_q_q;
	logic sign_r_q;

	// two's-complement magnitude.
	// the most negative word maps onto itself, which is its correct unsigned magnitude.
	function automatic div_word_t magnitude(input div_word_t value);
		div_word_t negated;
		negated = ~value + 1'b1;
		return value[div_width-1] ? negated : value;
	endfunction

	assign start_rise = start && !start_q;

	// a rise that lands while the core is busy is simply lost.
	assign accept = start_rise && !op.busy && !valid_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			start_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			start_q <= start;
			valid_q <= accept;    // pulse for the cycle after the accepting edge.
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dividend_mag_q <= magnitude(dividend);
			divisor_mag_q <= magnitude(divisor);
			sign_q_q <= dividend[div_width-1] ^ divisor[div_width-1];
			sign_r_q <= dividend[div_width-1];    // remainder follows the dividend.
		end
	end

	assign op.valid = valid_q;
	assign op.dividend_mag = dividend_mag_q;
	assign op.divisor_mag = divisor_mag_q;
	assign op.sign_q = sign_q_q;
	assign op.sign_r = sign_r_q;

endmodule

//--- div_restore_core.sv
`timescale 1ns/1ns

module div_restore_core (
	input logic clk,
	input logic rst,
	div_operand_if.core op,
	div_result_if.core res
);
	import div_pkg::*;

	// upper half is the partial remainder, lower half starts as the dividend
	// and fills with quotient bits as the dividend shifts out of the top.
	logic [2*div_width-1:0] pr_q;
	logic [2*div_width-1:0] pr_next;
	div_word_t divisor_q;
	logic sign_q_q;
	logic sign_r_q;
	logic [div_count_width-1:0] count_q;
	logic running_q;
	logic done_q;

	// one compare-subtract-shift step of restoring division.
	// the shifted partial remainder can exceed the word, so the compare is one bit wider.
	function automatic logic [2*div_width-1:0] restore_step(
		input logic [2*div_width-1:0] pr,
		input div_word_t d
	);
		logic [2*div_width:0] shifted;
		logic [div_width:0] upper;
		shifted = {pr, 1'b0};
		upper = shifted[2*div_width:div_width];
		if (upper >= {1'b0, d}) begin
			upper = upper - {1'b0, d};
			shifted[2*div_width:div_width] = upper;
			shifted[0] = 1'b1;    // quotient bit set.
		end
		// the remainder is below the divisor here, so the top bit is always clear.
		return shifted[2*div_width-1:0];
	endfunction

	// several steps chained in one cycle, most significant quotient bit first.
	always_comb begin
		pr_next = pr_q;
		for (int i = 0; i < div_bits_per_cycle; i++) begin
			pr_next = restore_step(pr_next, divisor_q);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			running_q <= 1'b0;
			done_q <= 1'b0;
			count_q <= '0;
		end else begin
			done_q <= 1'b0;
			if (op.valid) begin
				running_q <= 1'b1;
				count_q <= '0;
			end else if (running_q) begin
				count_q <= count_q + 1'b1;
				if (count_q == div_count_width'(div_iterations - 1)) begin
					running_q <= 1'b0;
					done_q <= 1'b1;    // last iteration retires at this edge.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (op.valid) begin
			pr_q <= {div_word_t'(0), op.dividend_mag};
			divisor_q <= op.divisor_mag;
			sign_q_q <= op.sign_q;
			sign_r_q <= op.sign_r;
		end else if (running_q) begin
			pr_q <= pr_next;
		end
	end

	// a zero divisor needs nothing extra.
	// every step subtracts zero, so the quotient fills with ones
	// and the dividend magnitude ends up in the upper half as the remainder.

	// busy also covers the result cycle, so the next load cannot come before edge 19.
	assign op.busy = running_q || done_q;

	assign res.valid = done_q;
	assign res.quotient_mag = pr_q[div_width-1:0];
	assign res.remainder_mag = pr_q[2*div_width-1:div_width];
	assign res.sign_q = sign_q_q;
	assign res.sign_r = sign_r_q;

endmodule

//--- div_result_fix.sv
`timescale 1ns/1ns

module div_result_fix (
	input logic clk,
	input logic rst,
	div_result_if.fix res,
	output logic ready,
	output div_pkg::div_word_t quotient,
	output div_pkg::div_word_t remainder
);
	import div_pkg::*;

	div_word_t quotient_signed;
	div_word_t remainder_signed;

	// negation wraps modulo the word, so a magnitude of 2^31 stays 0x80000000.
	function automatic div_word_t apply_sign(input div_word_t mag, input logic negative);
		div_word_t negated;
		negated = ~mag + 1'b1;
		return negative ? negated : mag;
	endfunction

	assign quotient_signed = apply_sign(res.quotient_mag, res.sign_q);
	assign remainder_signed = apply_sign(res.remainder_mag, res.sign_r);

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= 1'b0;
			quotient <= '0;
			remainder <= '0;
		end else begin
			ready <= res.valid;    // high for the single cycle after the result pulse.
			if (res.valid) begin
				quotient <= quotient_signed;
				remainder <= remainder_signed;
			end
		end
	end

endmodule

//--- divider_dshift_top.sv
`timescale 1ns/1ns

module divider_dshift_top (
	input logic clk,
	input logic rst,
	input div_pkg::div_word_t dividend,
	input div_pkg::div_word_t divisor,
	input logic start,
	output logic ready,
	output div_pkg::div_word_t quotient,
	output div_pkg::div_word_t remainder
);

	div_operand_if op_if ();
	div_result_if res_if ();

	// start edge detection, operand capture and sign split.
	div_sign_prep u_prep (
		.clk(clk),
		.rst(rst),
		.dividend(dividend),
		.divisor(divisor),
		.start(start),
		.op(op_if.prep)
	);

	div_restore_core u_core (
		.clk(clk),
		.rst(rst),
		.op(op_if.core),
		.res(res_if.core)
	);

	// signs go back on here, and the outputs hold until the next result.
	div_result_fix u_fix (
		.clk(clk),
		.rst(rst),
		.res(res_if.fix),
		.ready(ready),
		.quotient(quotient),
		.remainder(remainder)
	);

endmodule

//--- div_assert.sv
`timescale 1ns/1ns

module div_assert (
	input logic clk,
	input logic rst,
	input logic res_valid,
	input logic ready,
	input div_pkg::div_word_t quotient,
	input div_pkg::div_word_t remainder
);
	import div_pkg::*;

	int assert_failures = 0;

	// a new result needs a whole pass through the pipeline after the last one.
	ready_single_cycle: assert property (@(posedge clk) disable iff (rst)
		ready |=> !ready [*div_latency])
		else begin
			assert_failures++;
			$error("ready stayed high or came back before a full division");
		end

	// the outputs move only together with the rise of ready.
	results_hold: assert property (@(posedge clk) disable iff (rst)
		!$rose(ready) |-> $stable(quotient) && $stable(remainder))
		else begin
			assert_failures++;
			$error("results changed without a rise of ready");
		end

	ready_after_valid: assert property (@(posedge clk) disable iff (rst) res_valid |=> ready)
		else begin
			assert_failures++;
			$error("ready did not follow the result pulse");
		end

endmodule

bind div_result_fix div_assert u_assert (
	.clk(clk),
	.rst(rst),
	.res_valid(res.valid),
	.ready(ready),
	.quotient(quotient),
	.remainder(remainder)
);

//--- div_checker.sv
`timescale 1ns/1ns

module div_checker (
	input logic clk,
	input logic rst,
	input div_pkg::div_word_t dividend,
	input div_pkg::div_word_t divisor,
	input logic start,
	input logic ready,
	input div_pkg::div_word_t quotient,
	input div_pkg::div_word_t remainder,
	output int pass_count,
	output int fail_count
);
	import div_pkg::*;

	logic start_seen;
	logic pending;
	logic started;
	logic reset_ok;
	int edge_count;
	int accept_edge;
	div_word_t op_a;
	div_word_t op_b;
	logic [2*div_width-1:0] expected;

	task automatic check_result();
		logic ok;
		int latency;
		ok = 1'b1;
		latency = edge_count - 1 - accept_edge;    // ready rose one edge before we saw it.
		if (quotient !== expected[2*div_width-1:div_width]) begin
			$display("mismatch quotient: expected 0x%h, got 0x%h",
				expected[2*div_width-1:div_width], quotient);
			ok = 1'b0;
		end
		if (remainder !== expected[div_width-1:0]) begin
			$display("mismatch remainder: expected 0x%h, got 0x%h",
				expected[div_width-1:0], remainder);
			ok = 1'b0;
		end
		if (latency != div_latency) begin
			$display("mismatch ready latency: expected 0x%h, got 0x%h", div_latency, latency);
			ok = 1'b0;
		end
		if (ok)
			pass_count++;
		else
			fail_count++;
		$display("test %0d %s: dividend 0x%h divisor 0x%h", pass_count + fail_count,
			ok ? "pass" : "fail", op_a, op_b);
	endtask

	task automatic print_counts();
		$display("tests finished: %0d passed, %0d failed", pass_count, fail_count);
	endtask

	// mirrors the acceptance rule of the DUT from its ports alone.
	always @(posedge clk) begin
		if (rst) begin
			start_seen = 1'b0;
			pending = 1'b0;
			started = 1'b0;
			reset_ok = 1'b1;
			edge_count = 0;
			pass_count = 0;
			fail_count = 0;
		end else begin
			edge_count++;
			if (!started && (ready !== 1'b0 || quotient !== '0 || remainder !== '0))
				reset_ok = 1'b0;
			if (ready) begin
				if (!pending) begin
					$display("ready came with no division in flight at edge %0d", edge_count);
					fail_count++;
				end else begin
					check_result();
				end
				pending = 1'b0;
			end
			if (start && !start_seen && !pending) begin
				if (!started) begin
					started = 1'b1;
					if (reset_ok)
						pass_count++;
					else
						fail_count++;
					$display("test %0d %s: outputs after reset", pass_count + fail_count,
						reset_ok ? "pass" : "fail");
				end
				pending = 1'b1;
				accept_edge = edge_count;
				op_a = dividend;
				op_b = divisor;
				expected = divider_tb.div_ref(dividend, divisor);
			end
			start_seen = start;
		end
	end

endmodule

//--- divider_tb.sv
`timescale 1ns/1ns

module divider_tb;
	import div_pkg::*;

	localparam int clk_period = 20;
	localparam int reset_cycles = 10;
	localparam int random_tests = 200;
	localparam int corner_tests = 19;
	localparam int hold_cycles = 3 * (div_latency + 4);
	localparam int total_tests = random_tests + corner_tests + 2;
	// the two start discipline tests idle for a while on top of their own slot.
	localparam int watchdog_cycles = reset_cycles + total_tests * (div_latency + 4)
		+ hold_cycles + 2 * (div_latency + 4);

	logic clk;
	logic rst;
	logic start;
	div_word_t dividend;
	div_word_t divisor;
	logic ready;
	div_word_t quotient;
	div_word_t remainder;
	int pass_count;
	int fail_count;
	int tests_run;
	div_word_t rand_a;
	div_word_t rand_b;

	// most negative dividend, divisors of one, small dividends, equal pairs, zero divisors.
	div_word_t corner_a [corner_tests] = '{
		32'h8000_0000, 32'h8000_0000, 32'h8000_0000,
		32'h7fff_ffff, 32'h7fff_ffff, 32'hffff_cfc7, 32'hffff_cfc7,
		32'h0000_0005, 32'hffff_fffb, 32'h0000_0005, 32'hffff_fffb,
		32'h0000_1234, 32'hffff_f000, 32'h8000_0000, 32'h7fff_ffff,
		32'h0000_0064, 32'hffff_ff9c, 32'h0000_0000, 32'h8000_0000
	};
	div_word_t corner_b [corner_tests] = '{
		32'hffff_ffff, 32'h0000_0001, 32'h0000_0002,
		32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff,
		32'h0000_0007, 32'h0000_0007, 32'hffff_fff9, 32'hffff_fff9,
		32'h0000_1234, 32'hffff_f000, 32'h8000_0000, 32'h7fff_ffff,
		32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000
	};

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	divider_dshift_top uut (
		.clk(clk),
		.rst(rst),
		.dividend(dividend),
		.divisor(divisor),
		.start(start),
		.ready(ready),
		.quotient(quotient),
		.remainder(remainder)
	);

	div_checker chk (
		.clk(clk),
		.rst(rst),
		.dividend(dividend),
		.divisor(divisor),
		.start(start),
		.ready(ready),
		.quotient(quotient),
		.remainder(remainder),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	// bit-serial restoring division on magnitudes, then the sign rules.
	// returns the quotient in the upper word and the remainder in the lower word.
	function automatic logic [2*div_width-1:0] div_ref(input div_word_t a, input div_word_t b);
		div_word_t mag_a;
		div_word_t mag_b;
		div_word_t q;
		div_word_t r;
		logic [div_width:0] rem;
		mag_a = a[div_width-1] ? ~a + div_word_t'(1) : a;
		mag_b = b[div_width-1] ? ~b + div_word_t'(1) : b;
		rem = '0;
		q = '0;
		for (int i = div_width - 1; i >= 0; i--) begin
			rem = {rem[div_width-1:0], mag_a[i]};
			if (rem >= {1'b0, mag_b}) begin
				rem = rem - {1'b0, mag_b};
				q[i] = 1'b1;
			end
		end
		r = rem[div_width-1:0];
		if (a[div_width-1] ^ b[div_width-1])
			q = ~q + div_word_t'(1);    // wraps, so 2^31 stays 0x80000000.
		if (a[div_width-1])
			r = ~r + div_word_t'(1);
		return {q, r};
	endfunction

	task automatic wait_ready();
		do @(posedge clk); while (!ready);
	endtask

	task automatic run_division(input div_word_t a, input div_word_t b);
		start <= 1'b1;
		dividend <= a;
		divisor <= b;
		wait_ready();
		start <= 1'b0;
		@(posedge clk);
		tests_run++;
	endtask

	// start stays high across several result times, only the first rise counts.
	task automatic held_start();
		start <= 1'b1;
		dividend <= 32'h0000_0fff;
		divisor <= 32'hffff_fff0;
		wait_ready();
		repeat (hold_cycles) begin
			@(posedge clk);
			dividend <= $urandom;
			divisor <= $urandom;
		end
		start <= 1'b0;
		@(posedge clk);
		tests_run++;
	endtask

	task automatic rise_while_busy();
		start <= 1'b1;
		dividend <= 32'hfedc_ba98;
		divisor <= 32'h0000_0123;
		repeat (3) @(posedge clk);
		start <= 1'b0;
		repeat (2) @(posedge clk);
		start <= 1'b1;    // the core is busy, so these operands must be lost.
		dividend <= 32'h7654_3210;
		divisor <= 32'h0000_0003;
		repeat (2) @(posedge clk);
		start <= 1'b0;
		wait_ready();
		repeat (div_latency + 4) @(posedge clk);
		tests_run++;
	endtask

	initial begin
		void'($urandom(32'h0ce8_95ab));
		tests_run = 0;
		rst <= 1'b1;
		start <= 1'b0;
		dividend <= '0;
		divisor <= '0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);
		for (int i = 0; i < corner_tests; i++)
			run_division(corner_a[i], corner_b[i]);
		for (int i = 0; i < random_tests; i++) begin
			rand_a = $urandom;
			rand_b = $urandom;
			if (i % 2 == 1) begin
				rand_b = $urandom_range(1, 65535);    // small divisors give long quotients.
				if ($urandom % 2 == 1)
					rand_b = ~rand_b + div_word_t'(1);
			end
			run_division(rand_a, rand_b);
		end
		held_start();
		rise_while_busy();
		repeat (4) @(posedge clk);
		chk.print_counts();
		if (pass_count + fail_count != tests_run + 1)
			$display("expected %0d results but the checker saw %0d", tests_run + 1,
				pass_count + fail_count);
		if (uut.u_fix.u_assert.assert_failures != 0)
			$display("%0d protocol assertions failed", uut.u_fix.u_assert.assert_failures);
		if (fail_count == 0 && pass_count == tests_run + 1
			&& uut.u_fix.u_assert.assert_failures == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout after %0d cycles, the divider stopped answering", watchdog_cycles);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- tb.f
div_pkg.sv
div_operand_if.sv
div_result_if.sv
div_sign_prep.sv
div_restore_core.sv
div_result_fix.sv
divider_dshift_top.sv
div_assert.sv
div_checker.sv
divider_tb.sv

//--- Makefile
# Verilator build and run for the divider testbench.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module divider_tb -Mdir obj_dir -o divider_tb

run: compile
	./obj_dir/divider_tb | tee sim.log
	grep -q -F "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
